// File: design/mext_pkg.sv
// Shared M-extension definitions; QUEUE_DEPTH must be a power of two of at least 2
package mext_pkg;

    // Data path width
    localparam int XLEN = 32;

    // Issuer tag carried back with every result
    localparam int TAG_W = 4;

    // Entries per lane queue
    localparam int QUEUE_DEPTH = 4;

    // Issuing execute lanes
    localparam int NUM_LANES = 2;

    // Queue pointer and occupancy widths
    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // Most negative XLEN value as the signed divide overflow dividend
    localparam logic [XLEN-1:0] XLEN_MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    // RV32M operation codes
    typedef enum logic [3:0] {
        NONE   = 4'd0,
        MUL    = 4'd1,
        MULH   = 4'd2,
        MULHSU = 4'd3,
        MULHU  = 4'd4,
        DIV    = 4'd5,
        DIVU   = 4'd6,
        REM    = 4'd7,
        REMU   = 4'd8
    } mext_op_e;

    // One queued request, also the word that goes from arbiter to muldiv
    typedef struct packed {
        mext_op_e          op;
        logic [XLEN-1:0]   operand_1;
        logic [XLEN-1:0]   operand_2;
        logic [TAG_W-1:0]  tag;
    } mext_req_t;

endpackage

// File: design/mext_req_queue.sv
// Per-lane request FIFO; NONE pushes are discarded and a push when full is dropped and flagged
module mext_req_queue
    import mext_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,

    input  logic       push,
    input  mext_req_t  push_req,
    input  logic       pop,

    output logic       not_empty,
    output mext_req_t  head,
    output logic       overflow
);

    mext_req_t         mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;

    logic              push_has_op;
    logic              full;
    logic              do_push;
    logic              do_pop;

    assign push_has_op = push && (push_req.op != NONE);
    assign full        = (count == CNT_W'(QUEUE_DEPTH));
    assign not_empty   = (count != '0);
    assign head        = mem[rd_ptr];

    assign do_pop  = pop && not_empty;
    // A pop frees the slot in the same cycle so a full queue still takes the push
    assign do_push = push_has_op && (!full || do_pop);

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    // One-cycle strobe after a dropped issue
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            overflow <= 1'b0;
        end else begin
            overflow <= push_has_op && full && !do_pop;
        end
    end

endmodule

// File: design/mext_arbiter.sv
// Round-robin grant between two lane queues; lane 0 wins the first contended grant after reset
module mext_arbiter
    import mext_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,

    input  logic       lane0_not_empty,
    input  mext_req_t  lane0_head,
    input  logic       lane1_not_empty,
    input  mext_req_t  lane1_head,

    output logic       lane0_pop,
    output logic       lane1_pop,

    output logic       grant_valid,
    output logic       grant_lane,
    output mext_req_t  grant_req
);

    // Lane that wins when both queues are pending
    logic  prio_lane;

    always_comb begin
        grant_valid = 1'b0;
        grant_lane  = 1'b0;
        if (!flush) begin
            if (lane0_not_empty && lane1_not_empty) begin
                grant_valid = 1'b1;
                grant_lane  = prio_lane;
            end else if (lane0_not_empty) begin
                grant_valid = 1'b1;
                grant_lane  = 1'b0;
            end else if (lane1_not_empty) begin
                grant_valid = 1'b1;
                grant_lane  = 1'b1;
            end
        end
    end

    assign grant_req = grant_lane ? lane1_head : lane0_head;

    assign lane0_pop = grant_valid && !grant_lane;
    assign lane1_pop = grant_valid &&  grant_lane;

    // Point away from the last winner
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio_lane <= 1'b0;
        end else if (grant_valid) begin
            prio_lane <= !grant_lane;
        end
    end

endmodule

// File: design/muldiv.sv
// Single-cycle RV32M unit with registered result; division is combinational and sets the clock limit
module muldiv
    import mext_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,

    input  logic              grant_valid,
    input  logic              grant_lane,
    input  mext_req_t         grant_req,

    output logic              result_valid,
    output logic              result_lane,
    output logic [TAG_W-1:0]  result_tag,
    output logic [XLEN-1:0]   result
);

    logic [XLEN-1:0]            operand_1;
    logic [XLEN-1:0]            operand_2;
    logic                       divisor_is_zero;
    logic                       div_overflow;

    // Operands widened for the 2*XLEN products
    logic signed [2*XLEN-1:0]   operand_1_sext;
    logic signed [2*XLEN-1:0]   operand_2_sext;
    logic signed [2*XLEN-1:0]   operand_2_zext;
    logic [2*XLEN-1:0]          operand_1_zext;
    logic [2*XLEN-1:0]          operand_2_zext_u;

    logic [2*XLEN-1:0]          mult_uu;
    logic [2*XLEN-1:0]          mult_ss;
    logic [2*XLEN-1:0]          mult_su;

    logic [XLEN-1:0]            quot_s;
    logic [XLEN-1:0]            quot_u;
    logic [XLEN-1:0]            rem_s;
    logic [XLEN-1:0]            rem_u;

    logic [XLEN-1:0]            result_next;
    logic                       valid_next;

    assign operand_1 = grant_req.operand_1;
    assign operand_2 = grant_req.operand_2;

    assign divisor_is_zero = (operand_2 == '0);
    assign div_overflow    = (operand_1 == XLEN_MOST_NEG) && (operand_2 == '1);

    assign operand_1_sext   = $signed({{XLEN{operand_1[XLEN-1]}}, operand_1});
    assign operand_2_sext   = $signed({{XLEN{operand_2[XLEN-1]}}, operand_2});
    assign operand_2_zext   = $signed({{XLEN{1'b0}}, operand_2});
    assign operand_1_zext   = {{XLEN{1'b0}}, operand_1};
    assign operand_2_zext_u = {{XLEN{1'b0}}, operand_2};

    assign mult_uu = operand_1_zext * operand_2_zext_u;
    assign mult_ss = operand_1_sext * operand_2_sext;
    assign mult_su = operand_1_sext * operand_2_zext;

    // RISC-V divide by zero and signed overflow rules
    always_comb begin
        if (divisor_is_zero) begin
            quot_s = '1;
            quot_u = '1;
            rem_s  = operand_1;
            rem_u  = operand_1;
        end else begin
            quot_u = operand_1 / operand_2;
            rem_u  = operand_1 % operand_2;
            if (div_overflow) begin
                quot_s = operand_1;
                rem_s  = '0;
            end else begin
                quot_s = $signed(operand_1) / $signed(operand_2);
                rem_s  = $signed(operand_1) % $signed(operand_2);
            end
        end
    end

    always_comb begin
        valid_next  = grant_valid;
        result_next = '0;
        case (grant_req.op)
            MUL:     result_next = mult_ss[XLEN-1:0];
            MULH:    result_next = mult_ss[2*XLEN-1:XLEN];
            MULHSU:  result_next = mult_su[2*XLEN-1:XLEN];
            MULHU:   result_next = mult_uu[2*XLEN-1:XLEN];
            DIV:     result_next = quot_s;
            DIVU:    result_next = quot_u;
            REM:     result_next = rem_s;
            REMU:    result_next = rem_u;
            default: valid_next  = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            result_valid <= 1'b0;
            result_lane  <= 1'b0;
            result_tag   <= '0;
            result       <= '0;
        end else begin
            result_valid <= valid_next;
            result_lane  <= grant_lane;
            result_tag   <= grant_req.tag;
            result       <= result_next;
        end
    end

endmodule

// File: design/mext_top.sv
// M-extension block for two lanes; strobes only with no back-pressure so queue overflow is the only loss
module mext_top
    import mext_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,

    input  logic              issue_valid_0,
    input  mext_op_e          issue_op_0,
    input  logic [XLEN-1:0]   issue_operand_1_0,
    input  logic [XLEN-1:0]   issue_operand_2_0,
    input  logic [TAG_W-1:0]  issue_tag_0,

    input  logic              issue_valid_1,
    input  mext_op_e          issue_op_1,
    input  logic [XLEN-1:0]   issue_operand_1_1,
    input  logic [XLEN-1:0]   issue_operand_2_1,
    input  logic [TAG_W-1:0]  issue_tag_1,

    output logic              result_valid,
    output logic              result_lane,
    output logic [TAG_W-1:0]  result_tag,
    output logic [XLEN-1:0]   result,

    output logic              overflow_0,
    output logic              overflow_1
);

    mext_req_t               issue_req [NUM_LANES];
    mext_req_t               queue_head [NUM_LANES];
    logic [NUM_LANES-1:0]    queue_not_empty;
    logic [NUM_LANES-1:0]    queue_pop;

    logic                    grant_valid;
    logic                    grant_lane;
    mext_req_t               grant_req;

    // Pack loose issue ports into queue words
    assign issue_req[0] = '{op: issue_op_0, operand_1: issue_operand_1_0,
                            operand_2: issue_operand_2_0, tag: issue_tag_0};
    assign issue_req[1] = '{op: issue_op_1, operand_1: issue_operand_1_1,
                            operand_2: issue_operand_2_1, tag: issue_tag_1};

    mext_req_queue lane0_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .push      (issue_valid_0),
        .push_req  (issue_req[0]),
        .pop       (queue_pop[0]),
        .not_empty (queue_not_empty[0]),
        .head      (queue_head[0]),
        .overflow  (overflow_0)
    );

    mext_req_queue lane1_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .push      (issue_valid_1),
        .push_req  (issue_req[1]),
        .pop       (queue_pop[1]),
        .not_empty (queue_not_empty[1]),
        .head      (queue_head[1]),
        .overflow  (overflow_1)
    );

    mext_arbiter i_mext_arbiter (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .lane0_not_empty (queue_not_empty[0]),
        .lane0_head      (queue_head[0]),
        .lane1_not_empty (queue_not_empty[1]),
        .lane1_head      (queue_head[1]),
        .lane0_pop       (queue_pop[0]),
        .lane1_pop       (queue_pop[1]),
        .grant_valid     (grant_valid),
        .grant_lane      (grant_lane),
        .grant_req       (grant_req)
    );

    muldiv i_muldiv (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .grant_valid  (grant_valid),
        .grant_lane   (grant_lane),
        .grant_req    (grant_req),
        .result_valid (result_valid),
        .result_lane  (result_lane),
        .result_tag   (result_tag),
        .result       (result)
    );

endmodule

// File: testbench/mext_tb.sv
// Directed testbench for two lanes and QUEUE_DEPTH of at least 2; every wait ends on a cycle timeout
module mext_tb
    import mext_pkg::*;
();

    localparam int          HALF_PERIOD    = 4;
    localparam int          RESET_CYCLES   = 10;
    localparam logic [31:0] LFSR_SEED      = 32'ha7a45998;
    localparam logic [31:0] LFSR_TAPS      = 32'h80200003;
    localparam int          RESULT_TIMEOUT = 200;
    localparam int          RANDOM_REQS    = 40;
    localparam int          RANDOM_TIMEOUT = 4000;
    localparam int          BURST_CYCLES   = 10;

    logic              clk;
    logic              rst_n;
    logic              flush;
    logic              issue_valid_0;
    mext_op_e          issue_op_0;
    logic [XLEN-1:0]   issue_operand_1_0;
    logic [XLEN-1:0]   issue_operand_2_0;
    logic [TAG_W-1:0]  issue_tag_0;
    logic              issue_valid_1;
    mext_op_e          issue_op_1;
    logic [XLEN-1:0]   issue_operand_1_1;
    logic [XLEN-1:0]   issue_operand_2_1;
    logic [TAG_W-1:0]  issue_tag_1;
    logic              result_valid;
    logic              result_lane;
    logic [TAG_W-1:0]  result_tag;
    logic [XLEN-1:0]   result;
    logic              overflow_0;
    logic              overflow_1;

    // Expected {tag, value} per lane in issue order
    logic [TAG_W+XLEN-1:0]  exp_q0 [$];
    logic [TAG_W+XLEN-1:0]  exp_q1 [$];
    logic                   lane_log [$];

    logic [31:0]  lfsr;
    int           err_count;
    int           timeout_count;
    int           result_count;
    int           overflow_count_0;
    int           overflow_count_1;

    mext_top i_mext_top (
        .clk               (clk),
        .rst_n             (rst_n),
        .flush             (flush),
        .issue_valid_0     (issue_valid_0),
        .issue_op_0        (issue_op_0),
        .issue_operand_1_0 (issue_operand_1_0),
        .issue_operand_2_0 (issue_operand_2_0),
        .issue_tag_0       (issue_tag_0),
        .issue_valid_1     (issue_valid_1),
        .issue_op_1        (issue_op_1),
        .issue_operand_1_1 (issue_operand_1_1),
        .issue_operand_2_1 (issue_operand_2_1),
        .issue_tag_1       (issue_tag_1),
        .result_valid      (result_valid),
        .result_lane       (result_lane),
        .result_tag        (result_tag),
        .result            (result),
        .overflow_0        (overflow_0),
        .overflow_1        (overflow_1)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    // RV32M rules; signed division works on magnitudes and fixes the sign afterwards
    function automatic logic [XLEN-1:0] model_op(input mext_op_e op,
                                                 input logic [XLEN-1:0] a, b);
        logic [2*XLEN-1:0]  a_s;
        logic [2*XLEN-1:0]  b_s;
        logic [2*XLEN-1:0]  b_u;
        logic [2*XLEN-1:0]  prod;
        logic [XLEN-1:0]    mag_a;
        logic [XLEN-1:0]    mag_b;
        a_s   = {{XLEN{a[XLEN-1]}}, a};
        b_s   = {{XLEN{b[XLEN-1]}}, b};
        b_u   = {{XLEN{1'b0}}, b};
        mag_a = a[XLEN-1] ? -a : a;
        mag_b = b[XLEN-1] ? -b : b;
        case (op)
            MUL:    prod = a_s * b_s;
            MULH:   prod = a_s * b_s;
            MULHSU: prod = a_s * b_u;
            MULHU:  prod = {{XLEN{1'b0}}, a} * b_u;
            default: prod = '0;
        endcase
        case (op)
            MUL:                   return prod[XLEN-1:0];
            MULH, MULHSU, MULHU:   return prod[2*XLEN-1:XLEN];
            DIV:    if (b == '0) return '1;
                    else if (a[XLEN-1] ^ b[XLEN-1]) return -(mag_a / mag_b);
                    else return mag_a / mag_b;
            DIVU:   return (b == '0) ? '1 : a / b;
            REM:    if (b == '0) return a;
                    else if (a[XLEN-1]) return -(mag_a % mag_b);
                    else return mag_a % mag_b;
            REMU:   return (b == '0) ? a : a % b;
            default: return '0;
        endcase
    endfunction

    task automatic check_result(input logic [XLEN-1:0] expected, actual, input string what);
        if (actual !== expected) begin
            $display("error at %0t: %s expected %h got %h", $time, what, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_tag(input logic [TAG_W-1:0] expected, actual, input string what);
        if (actual !== expected) begin
            $display("error at %0t: %s expected %h got %h", $time, what, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_lane(input logic expected, actual, input string what);
        if (actual !== expected) begin
            $display("error at %0t: %s expected %b got %b", $time, what, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_count(input int expected, actual, input string what);
        if (actual != expected) begin
            $display("error at %0t: %s expected %0d got %0d", $time, what, expected, actual);
            err_count++;
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        logic [TAG_W+XLEN-1:0] entry;
        if (overflow_0) overflow_count_0++;
        if (overflow_1) overflow_count_1++;
        if (result_valid) begin
            result_count++;
            lane_log.push_back(result_lane);
            if ((result_lane ? exp_q1.size() : exp_q0.size()) == 0) begin
                $display("unexpected result from lane %0d at %0t", result_lane, $time);
                err_count++;
            end else begin
                if (result_lane) entry = exp_q1.pop_front();
                else entry = exp_q0.pop_front();
                check_tag(entry[TAG_W+XLEN-1:XLEN], result_tag, "result tag");
                check_result(entry[XLEN-1:0], result, "result value");
            end
        end
    end

    task automatic step_cycle();
        @(posedge clk);
        #1;
        issue_valid_0 = 1'b0;
        issue_valid_1 = 1'b0;
    endtask

    task automatic drive_lane(input int lane, input mext_op_e op,
                              input logic [XLEN-1:0] a, b,
                              input logic [TAG_W-1:0] tag, input bit expect_result);
        if (lane == 0) begin
            issue_valid_0     = 1'b1;
            issue_op_0        = op;
            issue_operand_1_0 = a;
            issue_operand_2_0 = b;
            issue_tag_0       = tag;
            if (expect_result) exp_q0.push_back({tag, model_op(op, a, b)});
        end else begin
            issue_valid_1     = 1'b1;
            issue_op_1        = op;
            issue_operand_1_1 = a;
            issue_operand_2_1 = b;
            issue_tag_1       = tag;
            if (expect_result) exp_q1.push_back({tag, model_op(op, a, b)});
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (RESET_CYCLES) step_cycle();
        rst_n = 1'b1;
        exp_q0.delete();
        exp_q1.delete();
        lane_log.delete();
    endtask

    task automatic wait_results();
        int cycles;
        cycles = 0;
        while ((exp_q0.size() != 0 || exp_q1.size() != 0) && cycles < RESULT_TIMEOUT) begin
            step_cycle();
            cycles++;
        end
        if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            $display("timeout waiting for result at %0t", $time);
            timeout_count++;
            exp_q0.delete();
            exp_q1.delete();
        end
    endtask

    task automatic test_idle_after_reset();
        int results_before;
        int ovf0_before;
        int ovf1_before;
        results_before = result_count;
        ovf0_before    = overflow_count_0;
        ovf1_before    = overflow_count_1;
        repeat (8) step_cycle();
        check_count(0, result_count - results_before, "results while idle");
        check_count(0, overflow_count_0 - ovf0_before, "lane 0 overflow while idle");
        check_count(0, overflow_count_1 - ovf1_before, "lane 1 overflow while idle");
    endtask

    task automatic test_each_op();
        mext_op_e         ops [10] = '{MUL, MULH, MULHSU, MULHU, DIV, DIV, DIVU, REM, REM, REMU};
        logic [XLEN-1:0]  op_a [10] = '{32'd7, 32'h80000000, 32'hfffffffe, 32'hffffffff,
                                        32'h80000000, 32'hfffffff9, 32'd1234, 32'h80000000,
                                        32'hfffffff9, 32'd100};
        logic [XLEN-1:0]  op_b [10] = '{32'hfffffffd, 32'h80000000, 32'hffffffff, 32'hffffffff,
                                        32'hffffffff, 32'd2, 32'd0, 32'hffffffff,
                                        32'd0, 32'd7};
        lane_log.delete();
        for (int i = 0; i < 10; i++) begin
            drive_lane(0, ops[i], op_a[i], op_b[i], 4'(i), 1'b1);
            step_cycle();
            wait_results();
        end
        check_count(10, lane_log.size(), "single lane results");
        foreach (lane_log[i]) check_lane(1'b0, lane_log[i], "result lane");
    endtask

    task automatic test_random_traffic();
        int               issued [2];
        int               cycles;
        mext_op_e         op;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
        issued = '{0, 0};
        cycles = 0;
        while ((issued[0] < RANDOM_REQS || issued[1] < RANDOM_REQS)
               && cycles < RANDOM_TIMEOUT) begin
            for (int lane = 0; lane < NUM_LANES; lane++) begin
                // One request in flight per lane
                if (issued[lane] < RANDOM_REQS
                    && (lane == 0 ? exp_q0.size() : exp_q1.size()) == 0
                    && rand_bits(1) != 0) begin
                    op = mext_op_e'(4'(rand_bits(3)) + 4'd1);
                    a  = rand_bits(32);
                    b  = (rand_bits(3) == 0) ? '0 : rand_bits(32);
                    drive_lane(lane, op, a, b, 4'(issued[lane]), 1'b1);
                    issued[lane]++;
                end
            end
            step_cycle();
            cycles++;
        end
        if (cycles >= RANDOM_TIMEOUT) begin
            $display("timeout issuing random requests at %0t", $time);
            timeout_count++;
        end
        wait_results();
    endtask

    task automatic test_both_lanes_same_cycle();
        apply_reset();
        for (int i = 0; i < 4; i++) begin
            drive_lane(0, MULHU, rand_bits(32), rand_bits(32), 4'(i), 1'b1);
            drive_lane(1, DIVU, rand_bits(32), rand_bits(16), 4'(8 + i), 1'b1);
            step_cycle();
        end
        wait_results();
        check_count(8, lane_log.size(), "results from both lanes");
        foreach (lane_log[i]) check_lane(1'(i % 2), lane_log[i], "alternating grant lane");
    endtask

    // Lane 1 drains at half rate under alternation and its queue fills after a few cycles
    task automatic test_queue_overflow();
        int    occ [2];
        int    dropped [2];
        int    ovf0_before;
        int    ovf1_before;
        logic  prio;
        logic  g_valid;
        logic  g_lane;
        bit    push;
        bit    pop;
        bit    accept;
        apply_reset();
        occ         = '{0, 0};
        dropped     = '{0, 0};
        prio        = 1'b0;
        ovf0_before = overflow_count_0;
        ovf1_before = overflow_count_1;
        for (int k = 0; k < BURST_CYCLES; k++) begin
            // Grant seen in the cycle before edge k
            g_valid = (occ[0] != 0) || (occ[1] != 0);
            g_lane  = (occ[0] != 0 && occ[1] != 0) ? prio : (occ[1] != 0);
            if (g_valid) prio = !g_lane;
            for (int lane = 0; lane < NUM_LANES; lane++) begin
                push   = (lane == 1) || (k % 2 == 0);
                pop    = g_valid && (g_lane == 1'(lane));
                accept = push && (occ[lane] < QUEUE_DEPTH || pop);
                occ[lane] = occ[lane] + int'(accept) - int'(pop);
                if (push && !accept) dropped[lane]++;
                if (push) drive_lane(lane, REMU, rand_bits(32), 32'(k + 1), 4'(k), accept);
            end
            step_cycle();
        end
        wait_results();
        check_count(dropped[0], overflow_count_0 - ovf0_before, "lane 0 overflow strobes");
        check_count(dropped[1], overflow_count_1 - ovf1_before, "lane 1 overflow strobes");
    endtask

    task automatic test_flush();
        int results_before;
        results_before = result_count;
        drive_lane(0, MULHU, rand_bits(32), rand_bits(32), 4'd1, 1'b0);
        drive_lane(1, DIV, rand_bits(32), rand_bits(32), 4'd2, 1'b0);
        step_cycle();
        drive_lane(0, MUL, rand_bits(32), rand_bits(32), 4'd3, 1'b0);
        drive_lane(1, REM, rand_bits(32), rand_bits(32), 4'd4, 1'b0);
        flush = 1'b1;
        step_cycle();
        flush = 1'b0;
        repeat (12) step_cycle();
        check_count(0, result_count - results_before, "results after flush");
        drive_lane(1, MULH, rand_bits(32), rand_bits(32), 4'd5, 1'b1);
        step_cycle();
        wait_results();
    endtask

    initial begin
        lfsr              = LFSR_SEED;
        err_count         = 0;
        timeout_count     = 0;
        result_count      = 0;
        overflow_count_0  = 0;
        overflow_count_1  = 0;
        rst_n             = 1'b0;
        flush             = 1'b0;
        issue_valid_0     = 1'b0;
        issue_op_0        = NONE;
        issue_operand_1_0 = '0;
        issue_operand_2_0 = '0;
        issue_tag_0       = '0;
        issue_valid_1     = 1'b0;
        issue_op_1        = NONE;
        issue_operand_1_1 = '0;
        issue_operand_2_1 = '0;
        issue_tag_1       = '0;
        apply_reset();
        test_idle_after_reset();
        test_each_op();
        test_random_traffic();
        test_both_lanes_same_cycle();
        test_queue_overflow();
        test_flush();
        $display("errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: files.f
design/mext_pkg.sv
design/mext_req_queue.sv
design/mext_arbiter.sv
design/muldiv.sv
design/mext_top.sv
testbench/mext_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module mext_tb -f files.f -o mext_sim \
    && ./obj_dir/mext_sim | tee /dev/stderr | grep -x "Regression passed" > /dev/null \
    && exit 0 \
    || exit 1
